// ==== Bender.yml ====
package:
  name: fetch_frontend

export_include_dirs:
  - include

sources:
  - include_dirs:
      - include
    files:
      - rtl/fetch_pkg.sv
      - rtl/isram_model.sv
      - rtl/fetch_unit.sv
      - rtl/fetch_buffer.sv
      - rtl/decode_stage.sv
      - rtl/frontend_top.sv
  - target: test
    include_dirs:
      - include
    files:
      - tests/frontend_checker.sv
      - tests/frontend_tb.sv

// ==== compile.f ====
+incdir+include
rtl/fetch_pkg.sv
rtl/isram_model.sv
rtl/fetch_unit.sv
rtl/fetch_buffer.sv
rtl/decode_stage.sv
rtl/frontend_top.sv
tests/frontend_checker.sv
tests/frontend_tb.sv

// ==== include/fetch_params.svh ====
// front-end sizing; FE_FBUF_DEPTH must stay a power of two and FE_XLEN is fixed at 32
`ifndef FETCH_PARAMS_SVH
`define FETCH_PARAMS_SVH

// data and byte address width
`define FE_XLEN 32

// word address width of the instruction sram, 256 words
// fetch uses pc bits [FE_MEM_AW+1:2], so addresses wrap every 1 KB
`define FE_MEM_AW 8

// entries in the fetch buffer
`define FE_FBUF_DEPTH 4

// first fetch address after reset
`define FE_RESET_PC 32'h0000_0000

`endif

// ==== rtl/decode_stage.sv ====
// decode consumer; only JAL redirects, every other opcode is treated as sequential
`timescale 1ns/1ps
`include "fetch_params.svh"

module decode_stage (
	input  logic                    clk,
	input  logic                    rst,
	input  logic                    empty,
	input  fetch_pkg::fetch_entry_t head,
	input  logic                    hold,
	output logic                    pop,
	output logic                    flush,
	output fetch_pkg::redirect_t    redirect,
	output logic                    issue_valid,
	output fetch_pkg::decoded_t     issue
);

	// pc of the next instruction on the correct path
	logic [`FE_XLEN-1:0] exp_pc;
	fetch_pkg::inst_u    word;
	logic                match;
	logic                is_jal;
	logic [`FE_XLEN-1:0] i_imm;
	logic [`FE_XLEN-1:0] j_imm;
	logic [`FE_XLEN-1:0] seq_pc;
	logic [`FE_XLEN-1:0] jal_target;

	assign word = head.inst;

	// head leaves every cycle it is there and not held
	assign pop = !empty && !hold;

	// wrong-path entries are popped without issue
	assign match       = (head.pc == exp_pc);
	assign issue_valid = pop && match;

	assign is_jal = (word.j_view.opcode == fetch_pkg::OPC_JAL);

	// I-type immediate, sign extended
	assign i_imm = {{(`FE_XLEN-12){word.i_view.imm[11]}}, word.i_view.imm};

	// J-type immediate unscrambled
	// raw [19]=imm20, [18:9]=imm10:1, [8]=imm11, [7:0]=imm19:12
	assign j_imm = {
		{(`FE_XLEN-21){word.j_view.imm[19]}},
		word.j_view.imm[19],
		word.j_view.imm[7:0],
		word.j_view.imm[8],
		word.j_view.imm[18:9],
		1'b0
	};

	assign seq_pc     = head.pc + `FE_XLEN'd4;
	assign jal_target = head.pc + j_imm;

	// one-cycle redirect and flush with the issued JAL
	assign redirect.taken  = issue_valid && is_jal;
	assign redirect.target = jal_target;
	assign flush           = redirect.taken;

	always_comb begin
		issue.pc   = head.pc;
		issue.inst = head.inst;
		issue.kind = is_jal ? fetch_pkg::KIND_JAL : fetch_pkg::KIND_OTHER;
		issue.imm  = is_jal ? j_imm : i_imm;
	end

	always_ff @(posedge clk) begin
		if (rst) begin
			exp_pc <= `FE_RESET_PC;
		end else if (issue_valid) begin
			exp_pc <= is_jal ? jal_target : seq_pc;
		end
	end

endmodule

// ==== rtl/fetch_buffer.sv ====
// circular fetch FIFO; depth must be a power of two, flush drops a same-cycle push
`timescale 1ns/1ps
`include "fetch_params.svh"

module fetch_buffer (
	input  logic                    clk,
	input  logic                    rst,
	input  logic                    push,
	input  fetch_pkg::fetch_entry_t push_entry,
	input  logic                    pop,
	input  logic                    flush,
	output logic                    full,
	output logic                    empty,
	output fetch_pkg::fetch_entry_t head
);

	localparam int PTR_W = $clog2(`FE_FBUF_DEPTH);

	fetch_pkg::fetch_entry_t mem [0:`FE_FBUF_DEPTH-1];
	logic [PTR_W-1:0]        wptr;
	logic [PTR_W-1:0]        rptr;
	logic [PTR_W:0]          count;
	logic                    do_push;
	logic                    do_pop;

	assign full  = (count == (PTR_W+1)'(`FE_FBUF_DEPTH));
	assign empty = (count == '0);
	assign head  = mem[rptr];

	// ignore strobes that would overflow or underflow
	assign do_push = push && !full && !flush;
	assign do_pop  = pop && !empty && !flush;

	always_ff @(posedge clk) begin
		if (do_push) begin
			mem[wptr] <= push_entry;
		end
	end

	// pointers wrap on their own width
	always_ff @(posedge clk) begin
		if (rst || flush) begin
			wptr  <= '0;
			rptr  <= '0;
			count <= '0;
		end else begin
			if (do_push) begin
				wptr <= wptr + 1'b1;
			end
			if (do_pop) begin
				rptr <= rptr + 1'b1;
			end
			// simultaneous push and pop leaves count alone
			if (do_push && !do_pop) begin
				count <= count + 1'b1;
			end else if (do_pop && !do_push) begin
				count <= count - 1'b1;
			end
		end
	end

endmodule

// ==== rtl/fetch_pkg.sv ====
// shared front-end types; needs fetch_params.svh on the include path, only RV32 word layouts
`include "fetch_params.svh"

package fetch_pkg;

	// major opcode of jal
	localparam logic [6:0] OPC_JAL = 7'b110_1111;

	// one fetched word with its address
	typedef struct packed {
		logic [`FE_XLEN-1:0] pc;
		logic [`FE_XLEN-1:0] inst;
	} fetch_entry_t;

	// nextpc bus from decode back to fetch
	typedef struct packed {
		logic                taken;
		logic [`FE_XLEN-1:0] target;
	} redirect_t;

	// read address channel payload
	typedef struct packed {
		logic [`FE_XLEN-1:0] addr;
	} isram_ar_t;

	// same instruction word seen as I-type or as J-type
	typedef union packed {
		struct packed {
			logic [11:0] imm;
			logic [4:0]  rs1;
			logic [2:0]  funct3;
			logic [4:0]  rd;
			logic [6:0]  opcode;
		} i_view;
		struct packed {
			// raw bits imm[20|10:1|11|19:12]
			logic [19:0] imm;
			logic [4:0]  rd;
			logic [6:0]  opcode;
		} j_view;
	} inst_u;

	typedef enum logic {
		KIND_OTHER = 1'b0,
		KIND_JAL   = 1'b1
	} inst_kind_e;

	// one issued instruction
	typedef struct packed {
		logic [`FE_XLEN-1:0] pc;
		logic [`FE_XLEN-1:0] inst;
		inst_kind_e          kind;
		logic [`FE_XLEN-1:0] imm;
	} decoded_t;

endpackage

// ==== rtl/fetch_unit.sv ====
// fetch producer; one outstanding read, stale requests still complete and are filtered in decode
`timescale 1ns/1ps
`include "fetch_params.svh"

module fetch_unit (
	input  logic                    clk,
	input  logic                    rst,
	input  logic                    ar_ready,
	input  logic                    r_valid,
	input  logic [`FE_XLEN-1:0]     r_data,
	input  logic                    full,
	input  fetch_pkg::redirect_t    redirect,
	output logic                    ar_valid,
	output fetch_pkg::isram_ar_t    ar,
	output logic                    r_ready,
	output logic                    push,
	output fetch_pkg::fetch_entry_t push_entry
);

	// read fsm states
	localparam logic [1:0] S_IDLE    = 2'd0;
	localparam logic [1:0] S_WAIT_AR = 2'd1;
	localparam logic [1:0] S_WAIT_R  = 2'd2;
	localparam logic [1:0] S_HOLD_R  = 2'd3;

	logic [1:0]          state;
	logic [1:0]          state_nxt;
	// address of the next request
	logic [`FE_XLEN-1:0] pc;
	// address of the request in flight
	logic [`FE_XLEN-1:0] req_addr;
	logic [`FE_XLEN-1:0] fetch_pc;
	logic                start;
	logic                r_hs;

	// redirect target wins over the sequential pc
	assign fetch_pc = redirect.taken ? redirect.target : pc;

	// new request only when the buffer has room
	assign start = (state == S_IDLE) && !full;

	// back-pressure through r_ready
	assign r_ready = ((state == S_WAIT_R) || (state == S_HOLD_R)) && !full;
	assign r_hs    = r_valid && r_ready;

	assign ar_valid = (state == S_WAIT_AR);
	assign ar.addr  = req_addr;

	// entry pairs in-flight address with returned word
	assign push            = r_hs;
	assign push_entry.pc   = req_addr;
	assign push_entry.inst = r_data;

	always_comb begin
		state_nxt = state;
		case (state)
			S_IDLE: begin
				if (!full) begin
					state_nxt = S_WAIT_AR;
				end
			end
			S_WAIT_AR: begin
				if (ar_ready) begin
					state_nxt = S_WAIT_R;
				end
			end
			S_WAIT_R: begin
				if (r_hs) begin
					state_nxt = S_IDLE;
				end else if (r_valid) begin
					// data is there but buffer full
					state_nxt = S_HOLD_R;
				end
			end
			S_HOLD_R: begin
				if (r_hs) begin
					state_nxt = S_IDLE;
				end
			end
			default: state_nxt = S_IDLE;
		endcase
	end

	always_ff @(posedge clk) begin
		if (rst) begin
			state <= S_IDLE;
			pc    <= `FE_RESET_PC;
		end else begin
			state <= state_nxt;
			if (start) begin
				pc <= fetch_pc + `FE_XLEN'd4;
			end else if (redirect.taken) begin
				// applies to the next request, not the one in flight
				pc <= redirect.target;
			end
		end
	end

	// held stable while ar_valid waits for ar_ready
	always_ff @(posedge clk) begin
		if (start) begin
			req_addr <= fetch_pc;
		end
	end

endmodule

// ==== rtl/frontend_top.sv ====
// fetch front end top; memory must be loaded through the load port before rst drops
`timescale 1ns/1ps
`include "fetch_params.svh"

module frontend_top (
	input  logic                  clk,
	input  logic                  rst,
	input  logic                  load_en,
	input  logic [`FE_MEM_AW-1:0] load_addr,
	input  logic [`FE_XLEN-1:0]   load_data,
	input  logic                  hold,
	output logic                  issue_valid,
	output fetch_pkg::decoded_t   issue
);

	// sram channels
	logic                    ar_valid;
	logic                    ar_ready;
	fetch_pkg::isram_ar_t    ar;
	logic                    r_valid;
	logic                    r_ready;
	logic [`FE_XLEN-1:0]     r_data;

	// buffer side
	logic                    push;
	fetch_pkg::fetch_entry_t push_entry;
	logic                    full;
	logic                    empty;
	fetch_pkg::fetch_entry_t head;
	logic                    pop;
	logic                    flush;

	// decode back to fetch
	fetch_pkg::redirect_t    redirect;

	isram_model u_isram (
		.clk       (clk),
		.rst       (rst),
		.load_en   (load_en),
		.load_addr (load_addr),
		.load_data (load_data),
		.ar_valid  (ar_valid),
		.ar        (ar),
		.r_ready   (r_ready),
		.ar_ready  (ar_ready),
		.r_valid   (r_valid),
		.r_data    (r_data)
	);

	fetch_unit u_fetch (
		.clk        (clk),
		.rst        (rst),
		.ar_ready   (ar_ready),
		.r_valid    (r_valid),
		.r_data     (r_data),
		.full       (full),
		.redirect   (redirect),
		.ar_valid   (ar_valid),
		.ar         (ar),
		.r_ready    (r_ready),
		.push       (push),
		.push_entry (push_entry)
	);

	fetch_buffer u_fbuf (
		.clk        (clk),
		.rst        (rst),
		.push       (push),
		.push_entry (push_entry),
		.pop        (pop),
		.flush      (flush),
		.full       (full),
		.empty      (empty),
		.head       (head)
	);

	decode_stage u_decode (
		.clk         (clk),
		.rst         (rst),
		.empty       (empty),
		.head        (head),
		.hold        (hold),
		.pop         (pop),
		.flush       (flush),
		.redirect    (redirect),
		.issue_valid (issue_valid),
		.issue       (issue)
	);

endmodule

// ==== rtl/isram_model.sv ====
// behavioural instruction sram, not for synthesis to a macro; one read in flight, no error response
`timescale 1ns/1ps
`include "fetch_params.svh"

module isram_model (
	input  logic                   clk,
	input  logic                   rst,
	input  logic                   load_en,
	input  logic [`FE_MEM_AW-1:0]  load_addr,
	input  logic [`FE_XLEN-1:0]    load_data,
	input  logic                   ar_valid,
	input  fetch_pkg::isram_ar_t   ar,
	input  logic                   r_ready,
	output logic                   ar_ready,
	output logic                   r_valid,
	output logic [`FE_XLEN-1:0]    r_data
);

	localparam logic [1:0] M_IDLE = 2'd0;
	localparam logic [1:0] M_WAIT = 2'd1;
	localparam logic [1:0] M_RESP = 2'd2;

	logic [`FE_XLEN-1:0] mem [0:(1 << `FE_MEM_AW)-1];
	logic [`FE_XLEN-1:0] rdata_q;
	logic [1:0]          state;
	logic [1:0]          wait_cnt;
	logic [2:0]          lfsr;
	logic                ar_hs;

	// only one request at a time, so accept only when idle
	assign ar_ready = (state == M_IDLE);
	assign r_valid  = (state == M_RESP);
	assign r_data   = rdata_q;
	assign ar_hs    = ar_valid && ar_ready;

	// load port, usable in reset too
	always_ff @(posedge clk) begin
		if (load_en) begin
			mem[load_addr] <= load_data;
		end
	end

	// word read at the address handshake, held until r handshake
	always_ff @(posedge clk) begin
		if (ar_hs) begin
			rdata_q <= mem[ar.addr[`FE_MEM_AW+1:2]];
		end
	end

	// x^3 + x^2 + 1, free running
	always_ff @(posedge clk) begin
		if (rst) begin
			lfsr <= 3'b001;
		end else begin
			lfsr <= {lfsr[1:0], lfsr[2] ^ lfsr[1]};
		end
	end

	// delay of lfsr[1:0]+1 cycles from address handshake to r_valid
	always_ff @(posedge clk) begin
		if (rst) begin
			state    <= M_IDLE;
			wait_cnt <= 2'd0;
		end else begin
			case (state)
				M_IDLE: begin
					if (ar_hs) begin
						wait_cnt <= lfsr[1:0];
						// zero extra delay answers in the very next cycle
						state <= (lfsr[1:0] == 2'd0) ? M_RESP : M_WAIT;
					end
				end
				M_WAIT: begin
					if (wait_cnt == 2'd1) begin
						state <= M_RESP;
					end
					wait_cnt <= wait_cnt - 2'd1;
				end
				M_RESP: begin
					if (r_ready) begin
						state <= M_IDLE;
					end
				end
				default: state <= M_IDLE;
			endcase
		end
	end

endmodule

// ==== tests/frontend_checker.sv ====
// issue stream checker; samples on the falling edge, assumes the image is loaded before rst drops
`timescale 1ns/1ps
`include "fetch_params.svh"

module frontend_checker (
	input  logic                  clk,
	input  logic                  rst,
	input  logic                  load_en,
	input  logic [`FE_MEM_AW-1:0] load_addr,
	input  logic [`FE_XLEN-1:0]   load_data,
	input  logic                  hold,
	input  logic                  issue_valid,
	input  fetch_pkg::decoded_t   issue,
	output int                    issue_count,
	output int                    value_errors,
	output int                    other_errors
);

	// own copy of the program, built from the load port
	logic [`FE_XLEN-1:0] image [0:(1 << `FE_MEM_AW)-1];
	// pc the next issue must carry
	logic [`FE_XLEN-1:0] model_pc;
	logic [`FE_XLEN-1:0] exp_inst;
	logic [`FE_XLEN-1:0] exp_imm;
	logic                exp_jal;
	// name of the pc check, set by what was issued last
	string               pc_test;
	int                  idle_cycles;
	logic                stall_seen;

	// jal offset, bits imm[20|10:1|11|19:12] sit in inst[31:12]
	function automatic logic [31:0] jal_offset(input logic [31:0] w);
		return {{11{w[31]}}, w[31], w[19:12], w[20], w[30:21], 1'b0};
	endfunction

	// I-type immediate in inst[31:20]
	function automatic logic [31:0] itype_offset(input logic [31:0] w);
		return {{20{w[31]}}, w[31:20]};
	endfunction

	task automatic compare(input string name, input logic [31:0] exp, input logic [31:0] act);
		if (act !== exp) begin
			value_errors++;
			$display("[FAIL] %s expected %h actual %h", name, exp, act);
		end
	endtask

	initial begin
		issue_count  = 0;
		value_errors = 0;
		other_errors = 0;
		model_pc     = `FE_RESET_PC;
		pc_test      = "reset_first_pc";
		idle_cycles  = 0;
		stall_seen   = 1'b0;
	end

	// inputs settle a little after the rising edge, so the falling edge is safe
	always @(negedge clk) begin
		if (load_en) begin
			image[load_addr] = load_data;
		end
		if (rst) begin
			if (issue_valid !== 1'b0) begin
				other_errors++;
				$display("issue_valid was not low during reset at %0t", $time);
			end
			model_pc    = `FE_RESET_PC;
			pc_test     = "reset_first_pc";
			idle_cycles = 0;
		end else if ($isunknown(issue_valid)) begin
			other_errors++;
			$display("issue_valid is unknown after reset at %0t", $time);
		end else if (issue_valid) begin
			if (hold) begin
				other_errors++;
				$display("an instruction was issued while hold was high at %0t", $time);
			end
			// expected fields from the image at the model pc
			exp_inst = image[model_pc[`FE_MEM_AW+1:2]];
			exp_jal  = (exp_inst[6:0] == fetch_pkg::OPC_JAL);
			exp_imm  = exp_jal ? jal_offset(exp_inst) : itype_offset(exp_inst);
			compare(pc_test, model_pc, issue.pc);
			compare("decode_inst", exp_inst, issue.inst);
			compare("decode_kind", {31'd0, exp_jal}, {31'd0, issue.kind});
			compare("decode_imm", exp_imm, issue.imm);
			// next pc on the correct path
			if (exp_jal) begin
				model_pc = model_pc + exp_imm;
				pc_test  = "jal_target";
			end else begin
				model_pc = model_pc + 32'd4;
				pc_test  = "seq_pc";
			end
			issue_count++;
			idle_cycles = 0;
		end else if (!hold) begin
			// only cycles where decode was free count toward a stall
			idle_cycles++;
			if (idle_cycles == 64 && !stall_seen) begin
				stall_seen = 1'b1;
				other_errors++;
				$display("fetch has stalled, nothing issued in 64 cycles with hold low, pc %h",
					model_pc);
			end
		end
	end

endmodule

// ==== tests/frontend_tb.sv ====
// front-end testbench; program is loaded under reset, hold is random, stops after 400 issues
`timescale 1ns/1ps
`include "fetch_params.svh"

module frontend_tb;

	localparam int ISSUE_TARGET = 400;
	localparam int RUN_LIMIT    = 20000;

	logic                  clk;
	logic                  rst;
	logic                  load_en;
	logic [`FE_MEM_AW-1:0] load_addr;
	logic [`FE_XLEN-1:0]   load_data;
	logic                  hold;
	logic                  issue_valid;
	fetch_pkg::decoded_t   issue;

	int                    issue_count;
	int                    value_errors;
	int                    other_errors;
	int                    timeouts;
	int                    cycles;
	logic [31:0]           lfsr_state;
	logic [31:0]           rnd;
	logic [31:0]           word;

	frontend_top dut0 (
		.clk         (clk),
		.rst         (rst),
		.load_en     (load_en),
		.load_addr   (load_addr),
		.load_data   (load_data),
		.hold        (hold),
		.issue_valid (issue_valid),
		.issue       (issue)
	);

	frontend_checker chk0 (
		.clk          (clk),
		.rst          (rst),
		.load_en      (load_en),
		.load_addr    (load_addr),
		.load_data    (load_data),
		.hold         (hold),
		.issue_valid  (issue_valid),
		.issue        (issue),
		.issue_count  (issue_count),
		.value_errors (value_errors),
		.other_errors (other_errors)
	);

	// 100 ns period
	always #50 clk = ~clk;

	// x^32 + x^22 + x^2 + x + 1, shifts left
	function automatic logic [31:0] lfsr_next(input logic [31:0] s);
		return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
	endfunction

	// one lfsr step per bit, newest bit lands in v[0]
	task automatic take_bits(input int n, output logic [31:0] v);
		int k;
		v = '0;
		for (k = 0; k < n; k++) begin
			lfsr_state = lfsr_next(lfsr_state);
			v = {v[30:0], lfsr_state[0]};
		end
	endtask

	// jal word from a byte offset and rd
	function automatic logic [31:0] encode_jal(input logic [31:0] off, input logic [4:0] rd);
		return {off[20], off[10:1], off[11], off[19:12], rd, fetch_pkg::OPC_JAL};
	endfunction

	// roughly one word in eight is a jal
	task automatic make_word(output logic [31:0] w);
		logic [31:0] r;
		logic [31:0] off;
		logic [31:0] rd;
		take_bits(3, r);
		if (r[2:0] == 3'd0) begin
			// -16..15 words, zero replaced by +16 words
			take_bits(5, r);
			off = ({27'd0, r[4:0]} - 32'd16) << 2;
			if (off == 32'd0) begin
				off = 32'd64;
			end
			take_bits(5, rd);
			w = encode_jal(off, rd[4:0]);
		end else begin
			take_bits(32, r);
			// keep jal only where it was meant
			if (r[6:0] == fetch_pkg::OPC_JAL) begin
				r[3] = ~r[3];
			end
			w = r;
		end
	endtask

	initial begin
		clk        = 1'b0;
		rst        = 1'b1;
		load_en    = 1'b0;
		load_addr  = '0;
		load_data  = '0;
		hold       = 1'b0;
		timeouts   = 0;
		lfsr_state = 32'hc17a;

		// whole program goes in while rst is high
		for (int a = 0; a < (1 << `FE_MEM_AW); a++) begin
			@(posedge clk);
			#1;
			make_word(word);
			load_en   = 1'b1;
			load_addr = a[`FE_MEM_AW-1:0];
			load_data = word;
		end
		@(posedge clk);
		#1;
		load_en = 1'b0;

		// then 10 plain reset cycles
		repeat (10) @(posedge clk);
		#1;
		rst = 1'b0;

		// random hold, about a third of the cycles
		cycles = 0;
		while (issue_count < ISSUE_TARGET && cycles < RUN_LIMIT) begin
			@(posedge clk);
			#1;
			take_bits(8, rnd);
			hold = (rnd[7:0] < 8'd85);
			cycles++;
		end
		hold = 1'b0;
		if (issue_count < ISSUE_TARGET) begin
			timeouts++;
			$display("timed out after %0d cycles with only %0d of %0d instructions issued",
				cycles, issue_count, ISSUE_TARGET);
		end

		@(posedge clk);
		$display("issues %0d  value errors %0d  other errors %0d  timeouts %0d",
			issue_count, value_errors, other_errors, timeouts);
		if (value_errors == 0 && other_errors == 0 && timeouts == 0) begin
			$display("RESULT: PASS");
		end else begin
			$display("RESULT: FAIL");
		end
		$finish;
	end

endmodule
